// ==== verilog/dwc_pkg.sv ====
package dwc_pkg;

  // Bus widths
  localparam int ADDR_W    = 32;
  localparam int ID_W      = 4;
  localparam int WIDE_DW   = 128;
  localparam int NARROW_DW = 32;

  // Narrow lanes per wide beat
  localparam int LANES = WIDE_DW / NARROW_DW;

  // Size codes as log2 of the byte count
  localparam int WIDE_SIZE_MAX   = 4;
  localparam int NARROW_SIZE_MAX = 2;

  // Buffering
  localparam int CMD_DEPTH  = 4;
  localparam int BEAT_DEPTH = 4;

  typedef enum logic [2:0] {
    SIZE_1B  = 3'd0,
    SIZE_2B  = 3'd1,
    SIZE_4B  = 3'd2,
    SIZE_8B  = 3'd3,
    SIZE_16B = 3'd4
  } ax_size_e;

  // Address request, same layout on both ports
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    ax_size_e          size;
  } ax_req_t;

  typedef struct packed {
    logic [WIDE_DW-1:0]   data;
    logic [WIDE_DW/8-1:0] strb;
    logic                 last;
  } wide_beat_t;

  typedef struct packed {
    logic [NARROW_DW-1:0]   data;
    logic [NARROW_DW/8-1:0] strb;
    logic                   last;
  } narrow_beat_t;

  // Per-burst info for the W serializer
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    ax_size_e          narrow_size;
    logic [1:0]        ratio_log2;
    logic [7:0]        wide_len;
  } split_cmd_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
  } b_resp_t;

  typedef enum logic {
    DSZ_IDLE = 1'b0,
    DSZ_HOLD = 1'b1
  } dsz_state_e;

endpackage

// ==== verilog/beat_fifo.sv ====
module beat_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH  = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  item_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output item_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  // Head entry falls through to the output
  assign out_data  = mem[rptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      end
      if (pop) begin
        rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Full leaves the write pointer lapped onto the head
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    !in_ready |-> (wptr == rptr));

  // Empty leaves the read pointer caught up with the write pointer
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !out_valid |-> (wptr == rptr));

endmodule

// ==== verilog/aw_downsizer.sv ====
module aw_downsizer (
  input  logic                clk,
  input  logic                rst_n,
  input  dwc_pkg::ax_req_t    s_aw,
  input  logic                s_aw_valid,
  output logic                s_aw_ready,
  output dwc_pkg::ax_req_t    m_aw,
  output logic                m_aw_valid,
  input  logic                m_aw_ready,
  output dwc_pkg::split_cmd_t cmd,
  output logic                cmd_valid,
  input  logic                cmd_ready
);

  import dwc_pkg::*;

  dsz_state_e  state;
  dsz_state_e  state_next;
  ax_size_e    narrow_size;
  logic [1:0]  ratio_log2;
  logic [10:0] len_mult;
  logic [10:0] len_full;
  ax_req_t     req_q;
  logic        accept;

  // Clamp size to the narrow bus width
  always_comb begin
    if (s_aw.size > ax_size_e'(NARROW_SIZE_MAX)) begin
      narrow_size = ax_size_e'(NARROW_SIZE_MAX);
    end else begin
      narrow_size = s_aw.size;
    end
  end

  assign ratio_log2 = 2'(s_aw.size - narrow_size);
  // Beats times ratio then back to len encoding
  assign len_mult   = (11'(s_aw.len) + 11'd1) << ratio_log2;
  assign len_full   = len_mult - 11'd1;

  // Only take a request when its command can be stored
  assign s_aw_ready = (state == DSZ_IDLE) && cmd_ready;
  assign accept     = s_aw_valid && s_aw_ready;

  assign cmd_valid        = s_aw_valid && (state == DSZ_IDLE);
  assign cmd.addr         = s_aw.addr;
  assign cmd.narrow_size  = narrow_size;
  assign cmd.ratio_log2   = ratio_log2;
  assign cmd.wide_len     = s_aw.len;

  always_comb begin
    state_next = state;
    case (state)
      DSZ_IDLE: if (accept) state_next = DSZ_HOLD;
      DSZ_HOLD: if (m_aw_ready) state_next = DSZ_IDLE;
      default:  state_next = DSZ_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DSZ_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Rewritten request held until m_aw accepts it
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q.id   <= s_aw.id;
      req_q.addr <= s_aw.addr;
      req_q.len  <= len_full[7:0];
      req_q.size <= narrow_size;
    end
  end

  assign m_aw       = req_q;
  assign m_aw_valid = (state == DSZ_HOLD);

  a_size_max: assert property (@(posedge clk) disable iff (!rst_n)
    s_aw_valid |-> s_aw.size <= ax_size_e'(WIDE_SIZE_MAX));

  // Address must be aligned to the request size
  a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    s_aw_valid |-> ({1'b0, s_aw.addr[3:0]} & ((5'd1 << s_aw.size) - 5'd1)) == 5'd0);

  a_len_fits: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> len_full[10:8] == 3'd0);

endmodule

// ==== verilog/w_serializer.sv ====
module w_serializer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  dwc_pkg::split_cmd_t   cmd,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  dwc_pkg::wide_beat_t   beat,
  input  logic                  beat_valid,
  output logic                  beat_ready,
  output dwc_pkg::narrow_beat_t m_w,
  output logic                  m_w_valid,
  input  logic                  m_w_ready
);

  import dwc_pkg::*;

  localparam int LANE_W = $clog2(LANES);
  localparam int STRB_W = NARROW_DW / 8;

  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] cur_addr;
  logic [ADDR_W-1:0] next_addr;
  logic              busy_q;
  logic [1:0]        sub_q;
  logic [7:0]        wide_cnt_q;
  logic [2:0]        ratio_m1;
  logic [LANE_W-1:0] lane;
  logic              sub_last;
  logic              wide_last;
  logic              fire;

  // First beat of a burst starts from the command address
  assign cur_addr  = busy_q ? addr_q : cmd.addr;
  assign next_addr = cur_addr + (ADDR_W'(1) << cmd.narrow_size);

  // Lane index from address bits 3..2
  assign lane = cur_addr[NARROW_SIZE_MAX +: LANE_W];

  assign ratio_m1  = (3'd1 << cmd.ratio_log2) - 3'd1;
  assign sub_last  = ({1'b0, sub_q} == ratio_m1);
  assign wide_last = (wide_cnt_q == cmd.wide_len);

  assign m_w_valid = cmd_valid && beat_valid;
  assign fire      = m_w_valid && m_w_ready;

  always_comb begin
    m_w.data = beat.data[lane * NARROW_DW +: NARROW_DW];
    m_w.strb = beat.strb[lane * STRB_W +: STRB_W];
    m_w.last = sub_last && wide_last;
  end

  // Wide beat leaves with its last slice, command with the burst's last beat
  assign beat_ready = fire && sub_last;
  assign cmd_ready  = fire && sub_last && wide_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      sub_q      <= '0;
      wide_cnt_q <= '0;
    end else if (fire) begin
      if (sub_last && wide_last) begin
        busy_q     <= 1'b0;
        sub_q      <= '0;
        wide_cnt_q <= '0;
      end else begin
        busy_q <= 1'b1;
        if (sub_last) begin
          sub_q      <= '0;
          wide_cnt_q <= wide_cnt_q + 8'd1;
        end else begin
          sub_q <= sub_q + 2'd1;
        end
      end
    end
  end

  // Running narrow byte address
  always_ff @(posedge clk) begin
    if (fire) begin
      addr_q <= next_addr;
    end
  end

  // Upstream W last must line up with the burst length from AW
  a_wide_last: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && beat_valid |-> beat.last == wide_last);

endmodule

// ==== verilog/dwc_write_top.sv ====
module dwc_write_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // Wide slave side
  input  dwc_pkg::ax_req_t      s_aw,
  input  logic                  s_aw_valid,
  output logic                  s_aw_ready,
  input  dwc_pkg::wide_beat_t   s_w,
  input  logic                  s_w_valid,
  output logic                  s_w_ready,
  output dwc_pkg::b_resp_t      s_b,
  output logic                  s_b_valid,
  input  logic                  s_b_ready,
  // Narrow master side
  output dwc_pkg::ax_req_t      m_aw,
  output logic                  m_aw_valid,
  input  logic                  m_aw_ready,
  output dwc_pkg::narrow_beat_t m_w,
  output logic                  m_w_valid,
  input  logic                  m_w_ready,
  input  dwc_pkg::b_resp_t      m_b,
  input  logic                  m_b_valid,
  output logic                  m_b_ready
);

  import dwc_pkg::*;

  split_cmd_t dsz_cmd;
  logic       dsz_cmd_valid;
  logic       dsz_cmd_ready;
  split_cmd_t ser_cmd;
  logic       ser_cmd_valid;
  logic       ser_cmd_ready;
  wide_beat_t ser_beat;
  logic       ser_beat_valid;
  logic       ser_beat_ready;

  aw_downsizer u_dsz (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_aw       (s_aw),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .m_aw       (m_aw),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .cmd        (dsz_cmd),
    .cmd_valid  (dsz_cmd_valid),
    .cmd_ready  (dsz_cmd_ready)
  );

  // Outstanding burst commands
  beat_fifo #(
    .item_t (split_cmd_t),
    .DEPTH  (CMD_DEPTH)
  ) u_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (dsz_cmd),
    .in_valid  (dsz_cmd_valid),
    .in_ready  (dsz_cmd_ready),
    .out_data  (ser_cmd),
    .out_valid (ser_cmd_valid),
    .out_ready (ser_cmd_ready)
  );

  // Wide W beats straight from the slave port
  beat_fifo #(
    .item_t (wide_beat_t),
    .DEPTH  (BEAT_DEPTH)
  ) u_beat_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (s_w),
    .in_valid  (s_w_valid),
    .in_ready  (s_w_ready),
    .out_data  (ser_beat),
    .out_valid (ser_beat_valid),
    .out_ready (ser_beat_ready)
  );

  w_serializer u_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (ser_cmd),
    .cmd_valid  (ser_cmd_valid),
    .cmd_ready  (ser_cmd_ready),
    .beat       (ser_beat),
    .beat_valid (ser_beat_valid),
    .beat_ready (ser_beat_ready),
    .m_w        (m_w),
    .m_w_valid  (m_w_valid),
    .m_w_ready  (m_w_ready)
  );

  // One B per narrow burst so IDs already match
  assign s_b       = m_b;
  assign s_b_valid = m_b_valid;
  assign m_b_ready = s_b_ready;

endmodule

// ==== test/tb_dwc_table.svh ====
`ifndef TB_DWC_TABLE_SVH
`define TB_DWC_TABLE_SVH

// Row fields are id, address, size, len and expected narrow beat count
typedef struct packed {
  logic [ID_W-1:0]   id;
  logic [ADDR_W-1:0] addr;
  ax_size_e          size;
  logic [7:0]        len;
  logic [8:0]        exp_beats;
} req_row_t;

localparam int NUM_REQ = 12;

req_row_t req_table [NUM_REQ] = '{
  '{4'h1, 32'h0000_1000, SIZE_1B,  8'd0, 9'd1},
  '{4'h2, 32'h0000_1003, SIZE_1B,  8'd3, 9'd4},
  '{4'h3, 32'h0000_2002, SIZE_2B,  8'd2, 9'd3},
  '{4'h4, 32'h0000_200e, SIZE_2B,  8'd1, 9'd2},
  '{4'h5, 32'h0000_3004, SIZE_4B,  8'd3, 9'd4},
  '{4'h6, 32'h0000_300c, SIZE_4B,  8'd0, 9'd1},
  '{4'h7, 32'h0000_4008, SIZE_8B,  8'd0, 9'd2},
  '{4'h8, 32'h0000_4000, SIZE_8B,  8'd2, 9'd6},
  '{4'h9, 32'h0000_5000, SIZE_16B, 8'd0, 9'd4},
  '{4'ha, 32'h0000_5010, SIZE_16B, 8'd3, 9'd16},
  '{4'hb, 32'h0000_6008, SIZE_8B,  8'd4, 9'd10},
  '{4'hc, 32'h0000_7001, SIZE_1B,  8'd5, 9'd6}
};

function automatic ax_req_t table_req(input int i);
  ax_req_t req;
  req.id   = req_table[i].id;
  req.addr = req_table[i].addr;
  req.len  = req_table[i].len;
  req.size = req_table[i].size;
  return req;
endfunction

// Narrow size never exceeds 4 bytes
function automatic ax_size_e narrow_size_of(input ax_size_e s);
  return (s > SIZE_4B) ? SIZE_4B : s;
endfunction

function automatic int ratio_of(input ax_size_e s);
  return 1 << (int'(s) - int'(narrow_size_of(s)));
endfunction

function automatic ax_req_t downsized_req(input ax_req_t req);
  ax_req_t nr;
  nr      = req;
  nr.size = narrow_size_of(req.size);
  nr.len  = 8'((int'(req.len) + 1) * ratio_of(req.size) - 1);
  return nr;
endfunction

// Narrow beat j of a burst cut from its wide beat
function automatic narrow_beat_t sliced_beat(input ax_req_t req, input wide_beat_t wb,
                                             input int j, input int total);
  logic [ADDR_W-1:0] a;
  logic [1:0]        lane;
  narrow_beat_t      nb;
  a       = req.addr + ADDR_W'(j << int'(narrow_size_of(req.size)));
  // Lane from byte address bits 3..2
  lane    = a[3:2];
  nb.data = wb.data[lane * NARROW_DW +: NARROW_DW];
  nb.strb = wb.strb[lane * (NARROW_DW / 8) +: NARROW_DW / 8];
  nb.last = (j == total - 1);
  return nb;
endfunction

`endif

// ==== test/tb_dwc_write.sv ====
module tb_dwc_write;

  import dwc_pkg::*;

  `include "tb_dwc_table.svh"

  logic         clk;
  logic         rst_n;
  ax_req_t      s_aw;
  logic         s_aw_valid;
  logic         s_aw_ready;
  wide_beat_t   s_w;
  logic         s_w_valid;
  logic         s_w_ready;
  b_resp_t      s_b;
  logic         s_b_valid;
  logic         s_b_ready;
  ax_req_t      m_aw;
  logic         m_aw_valid;
  logic         m_aw_ready;
  narrow_beat_t m_w;
  logic         m_w_valid;
  logic         m_w_ready;
  b_resp_t      m_b;
  logic         m_b_valid;
  logic         m_b_ready;

  ax_req_t         exp_aw [NUM_REQ];
  b_resp_t         exp_b [NUM_REQ];
  logic [ID_W-1:0] aw_ids [NUM_REQ];
  int              entry_err [NUM_REQ];
  wide_beat_t      wide_q [$];
  narrow_beat_t    exp_w_q [$];
  int              errors = 0;
  int              checks = 0;
  int              aw_cnt = 0;
  int              w_burst = 0;
  int              burst_beats = 0;
  int              b_sent = 0;
  int              b_got = 0;
  int              total_beats = 0;
  int              cycle_cnt = 0;
  int              cycle_limit = 0;

  dwc_write_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_aw       (s_aw),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .s_w        (s_w),
    .s_w_valid  (s_w_valid),
    .s_w_ready  (s_w_ready),
    .s_b        (s_b),
    .s_b_valid  (s_b_valid),
    .s_b_ready  (s_b_ready),
    .m_aw       (m_aw),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_w        (m_w),
    .m_w_valid  (m_w_valid),
    .m_w_ready  (m_w_ready),
    .m_b        (m_b),
    .m_b_valid  (m_b_valid),
    .m_b_ready  (m_b_ready)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic check_aw(input int idx, input ax_req_t got, input ax_req_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED m_aw entry %0d: expected %h, got %h", idx, exp, got);
      errors++;
      entry_err[idx]++;
    end
  endtask

  task automatic check_w(input int idx, input narrow_beat_t got, input narrow_beat_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED m_w entry %0d beat %0d: expected %h, got %h",
               idx, burst_beats, exp, got);
      errors++;
      entry_err[idx]++;
    end
  endtask

  task automatic check_b(input int idx, input b_resp_t got, input b_resp_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED s_b entry %0d: expected %h, got %h", idx, exp, got);
      errors++;
      entry_err[idx]++;
    end
  endtask

  // Random wide data and the narrow traffic it should turn into
  task automatic build_expected();
    ax_req_t    req;
    wide_beat_t wb;
    int         r;
    int         total;
    int         i;
    int         k;
    int         s;
    int         limit;
    limit = 0;
    for (i = 0; i < NUM_REQ; i++) begin
      req         = table_req(i);
      r           = ratio_of(req.size);
      total       = (int'(req.len) + 1) * r;
      exp_aw[i]   = downsized_req(req);
      exp_b[i].id = req.id;
      for (k = 0; k <= int'(req.len); k++) begin
        wb.data = {$urandom, $urandom, $urandom, $urandom};
        wb.strb = 16'($urandom);
        wb.last = (k == int'(req.len));
        wide_q.push_back(wb);
        for (s = 0; s < r; s++) begin
          exp_w_q.push_back(sliced_beat(req, wb, k * r + s, total));
        end
      end
      limit += 4 * (int'(req_table[i].exp_beats) + 10);
    end
    total_beats = exp_w_q.size();
    cycle_limit = limit;
  endtask

  task automatic send_requests();
    int i;
    for (i = 0; i < NUM_REQ; i++) begin
      @(negedge clk);
      s_aw       = table_req(i);
      s_aw_valid = 1'b1;
      @(posedge clk);
      while (!s_aw_ready) @(posedge clk);
    end
    @(negedge clk);
    s_aw_valid = 1'b0;
  endtask

  task automatic send_wide_beats();
    int i;
    for (i = 0; i < wide_q.size(); i++) begin
      @(negedge clk);
      s_w       = wide_q[i];
      s_w_valid = 1'b1;
      @(posedge clk);
      while (!s_w_ready) @(posedge clk);
    end
    @(negedge clk);
    s_w_valid = 1'b0;
  endtask

  // Roughly one cycle in three stalled on each master channel
  task automatic drive_backpressure();
    forever begin
      @(negedge clk);
      m_aw_ready = ($urandom % 3) != 0;
      m_w_ready  = ($urandom % 3) != 0;
    end
  endtask

  // Slave model answering one B once the AW and the W last of a burst were both seen
  always @(negedge clk) begin
    if (m_b_valid && m_b_ready) begin
      b_sent++;
    end
    m_b_valid = 1'b0;
    if (rst_n && b_sent < aw_cnt && b_sent < w_burst && b_sent < NUM_REQ) begin
      m_b.id    = aw_ids[b_sent];
      m_b_valid = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (rst_n && m_aw_valid && m_aw_ready) begin
      if (aw_cnt < NUM_REQ) begin
        check_aw(aw_cnt, m_aw, exp_aw[aw_cnt]);
        aw_ids[aw_cnt] = m_aw.id;
      end else begin
        $display("ERROR: m_aw issued more requests than the table holds");
        errors++;
      end
      aw_cnt++;
    end
  end

  always @(posedge clk) begin
    if (rst_n && m_w_valid && m_w_ready) begin
      if (exp_w_q.size() == 0 || w_burst >= NUM_REQ) begin
        $display("ERROR: m_w carried a beat after all expected beats were seen");
        errors++;
      end else begin
        check_w(w_burst, m_w, exp_w_q.pop_front());
      end
      burst_beats++;
      if (m_w.last) begin
        if (w_burst < NUM_REQ) begin
          checks++;
          if (burst_beats != int'(req_table[w_burst].exp_beats)) begin
            $display("FAILED m_w beat count entry %0d: expected %h, got %h",
                     w_burst, req_table[w_burst].exp_beats, burst_beats);
            errors++;
            entry_err[w_burst]++;
          end
        end
        burst_beats = 0;
        w_burst++;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && s_b_valid && s_b_ready) begin
      if (b_got < NUM_REQ) begin
        check_b(b_got, s_b, exp_b[b_got]);
        $display("Entry %0d id %h size %0d len %0d: %0d narrow beats, %0d errors",
                 b_got, req_table[b_got].id, req_table[b_got].size,
                 req_table[b_got].len, req_table[b_got].exp_beats, entry_err[b_got]);
      end else begin
        $display("ERROR: s_b returned more responses than requests were sent");
        errors++;
      end
      b_got++;
    end
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: the run hung, %0d of %0d responses after %0d cycles",
             b_got, NUM_REQ, cycle_limit);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h670d));
    rst_n      = 1'b0;
    s_aw       = '0;
    s_aw_valid = 1'b0;
    s_w        = '0;
    s_w_valid  = 1'b0;
    s_b_ready  = 1'b1;
    m_aw_ready = 1'b0;
    m_w_ready  = 1'b0;
    m_b        = '0;
    m_b_valid  = 1'b0;
    build_expected();
    fork
      drive_backpressure();
    join_none
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      send_requests();
      send_wide_beats();
    join
    wait (b_got == NUM_REQ);
    // Idle a little so stray beats or responses still get caught
    repeat (10) @(posedge clk);
    if (aw_cnt != NUM_REQ || w_burst != NUM_REQ || exp_w_q.size() != 0) begin
      $display("ERROR: traffic count off, %0d requests, %0d bursts, %0d beats unseen",
               aw_cnt, w_burst, exp_w_q.size());
      errors++;
    end
    $display("Checks %0d, errors %0d, requests %0d, narrow beats %0d, cycles %0d",
             checks, errors, NUM_REQ, total_beats, cycle_cnt);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+test
verilog/dwc_pkg.sv
verilog/beat_fifo.sv
verilog/aw_downsizer.sv
verilog/w_serializer.sv
verilog/dwc_write_top.sv
test/tb_dwc_write.sv
